/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= fpu_axil_tb
FILELIST ?= verilog.f
BUILD    ?= obj_dir
LOG      ?= sim.log
RUN_ARGS ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/fpu_axil_chk.sv */
`timescale 1ns/1ps

module fpu_axil_chk (
	input logic clk,
	input logic rst_n,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input fpu_pkg::axi_data_t rdata,
	input logic start,
	input logic add_vld,
	input logic mul_vld,
	input logic done
);
	import fpu_pkg::*;

	int err_count = 0; // assertion failures so far
	logic seen_add; // adder result arrived since the last start
	logic seen_mul;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			seen_add <= 1'b0;
			seen_mul <= 1'b0;
		end
		else if (start)
		begin
			seen_add <= 1'b0;
			seen_mul <= 1'b0;
		end
		else
		begin
			seen_add <= seen_add | add_vld;
			seen_mul <= seen_mul | mul_vld;
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
	else
	begin
		$error("bvalid dropped before bready was seen");
		err_count++;
	end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else
	begin
		$error("rvalid dropped or rdata changed before rready was seen");
		err_count++;
	end

	a_add_latency: assert property (@(posedge clk) disable iff (!rst_n)
		add_vld == $past(start, add_latency))
	else
	begin
		$error("adder valid does not follow start by the adder latency");
		err_count++;
	end

	a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
		mul_vld == $past(start, mul_latency))
	else
	begin
		$error("multiplier valid does not follow start by the multiplier latency");
		err_count++;
	end

	// done only once both results are in
	a_done_after_both: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> seen_add && seen_mul)
	else
	begin
		$error("done rose before both pipeline results arrived");
		err_count++;
	end

endmodule

bind fpu_axil_top fpu_axil_chk u_chk (
	.clk(clk), .rst_n(rst_n),
	.bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata),
	.start(start), .add_vld(add_vld), .mul_vld(mul_vld), .done(done)
);

/* sim/fpu_axil_tb.sv */
`timescale 1ns/1ps

module fpu_axil_tb;
	import fpu_pkg::*;

	localparam int cycle_limit = 2000; // ~20 operations of under 60 cycles, with margin
	localparam int poll_limit = 16;

	logic clk;
	logic rst_n;
	axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	axi_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	axi_resp_t bresp;
	logic bvalid;
	logic bready;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic rvalid;
	logic rready;

	int cycles = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	fpu_axil_top dut (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// value of a float under the hidden-one rule, exponent 0 included
	function automatic real to_real(input float_t x);
		logic [63:0] d;
		d = {x[31], 11'(int'(x[30:23]) - exp_bias + 1023), x[22:0], 29'd0};
		return $bitstoreal(d);
	endfunction

	// exact result to float; an exponent above carry_above forces the last fraction bit
	task automatic apply_rules(input real r, input int carry_above,
		output float_t res, output ovf_t flags);
		logic [63:0] d;
		int e;
		d = $realtobits(r);
		e = int'(d[62:52]) - 1023 + exp_bias;
		if (r == 0.0 || e < 0)
		begin
			res = '0;
			flags = 2'b01;
		end
		else if (e >= 255)
		begin
			res = {d[63], 8'hFF, 23'h7FFFFF};
			flags = 2'b10;
		end
		else
		begin
			res = {d[63], e[7:0], d[51:29]};
			if (e > carry_above)
				res[0] = 1'b1;
			flags = 2'b00;
		end
	endtask

	task automatic expect_add(input float_t a, input float_t b,
		output float_t res, output ovf_t flags);
		int e_max;
		e_max = (a[30:23] > b[30:23]) ? int'(a[30:23]) : int'(b[30:23]);
		apply_rules(to_real(a) + to_real(b), e_max, res, flags);
	endtask

	task automatic expect_mul(input float_t a, input float_t b,
		output float_t res, output ovf_t flags);
		apply_rules(to_real(a) * to_real(b), 1000, res, flags); // truncation only
	endtask

	// random sign, exponent as given, top 4 fraction bits random
	function automatic float_t small_float(input exp_t e);
		float_t f;
		f[31] = 1'($urandom % 2);
		f[30:23] = e;
		f[22:0] = {4'($urandom % 16), 19'd0};
		return f;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("FAILED %s: expected %08h, actual %08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input int hold,
		output axi_resp_t resp);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!(awready && wready))
			@(negedge clk);
		@(negedge clk); // handshake took place on the edge before
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk);
		repeat (hold) @(negedge clk);
		resp = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, input int hold,
		output axi_data_t data, output axi_resp_t resp);
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		while (!arready)
			@(negedge clk);
		do
			@(negedge clk);
		while (!rvalid);
		arvalid = 1'b0;
		repeat (hold) @(negedge clk);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// one full operation: operands, start, poll, then sum, product and status
	task automatic run_op(input string name, input float_t a, input float_t b);
		float_t exp_sum;
		float_t exp_prod;
		ovf_t add_f;
		ovf_t mul_f;
		axi_data_t val;
		axi_data_t status;
		axi_resp_t resp;
		int polls;
		int err_before;
		err_before = errors;
		expect_add(a, b, exp_sum, add_f);
		expect_mul(a, b, exp_prod, mul_f);
		axi_write(reg_op_a, a, 0, resp);
		axi_write(reg_op_b, b, 0, resp);
		axi_write(reg_ctrl, 32'd1, 0, resp);
		check_val({name, " ctrl resp"}, 32'(resp_okay), 32'(resp));
		status = '0;
		polls = 0;
		while (!status[1] && polls < poll_limit)
		begin
			axi_read(reg_status, 0, status, resp);
			polls++;
		end
		if (!status[1])
		begin
			$display("test %s: done never showed in status after %0d polls", name, polls);
			errors++;
		end
		axi_read(reg_sum, 0, val, resp);
		check_val({name, " sum"}, exp_sum, val);
		axi_read(reg_prod, 0, val, resp);
		check_val({name, " prod"}, exp_prod, val);
		check_val({name, " status"}, {26'd0, mul_f, add_f, 2'b10}, status);
		end_test(name, err_before);
	endtask

	initial
	begin
		float_t a;
		float_t b;
		float_t exp_s;
		float_t exp_p;
		ovf_t add_f;
		ovf_t mul_f;
		exp_t ea;
		axi_data_t val;
		axi_resp_t resp;
		int err_before;
		int total;

		void'($urandom(32'h1aa6));
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		run_op("exact_basic", 32'h3FC0_0000, 32'h3E80_0000); // 1.5 and 0.25
		for (int i = 0; i < 8; i++)
		begin
			ea = 8'(120 + int'($urandom % 16));
			a = small_float(ea);
			b = small_float(8'(int'(ea) - 4 + int'($urandom % 9)));
			run_op($sformatf("exact_rand_%0d", i), a, b);
		end
		run_op("carry", 32'h3F80_0000, 32'h3F80_0000);
		run_op("cancel", 32'h4040_0000, 32'hC020_0000); // 3.0 and -2.5
		run_op("x_minus_x", 32'h3FA0_0000, 32'hBFA0_0000);
		run_op("overflow", 32'h7F00_0000, 32'h7F40_0000);

		err_before = errors;
		expect_add(32'h7F00_0000, 32'h7F40_0000, exp_s, add_f); // sum left by the overflow case
		axi_read(6'h20, 0, val, resp);
		check_val("slverr read resp", 32'(resp_slverr), 32'(resp));
		axi_write(reg_sum, 32'h0BAD_0BAD, 0, resp);
		check_val("slverr write resp", 32'(resp_slverr), 32'(resp));
		axi_read(reg_sum, 0, val, resp);
		check_val("slverr sum kept", exp_s, val);
		end_test("slverr", err_before);

		// second ctrl write lands while the first operation is still in flight
		err_before = errors;
		a = 32'h4040_0000;
		b = 32'h3F20_0000;
		expect_add(a, b, exp_s, add_f);
		expect_mul(a, b, exp_p, mul_f);
		axi_write(reg_op_a, a, 0, resp);
		axi_write(reg_op_b, b, 0, resp);
		axi_write(reg_ctrl, 32'd1, 0, resp);
		axi_write(reg_ctrl, 32'd1, 0, resp);
		check_val("start_busy ctrl resp", 32'(resp_okay), 32'(resp));
		axi_read(reg_status, 0, val, resp);
		check_val("start_busy status", {26'd0, mul_f, add_f, 2'b10}, val);
		axi_read(reg_sum, 0, val, resp);
		check_val("start_busy sum", exp_s, val);
		axi_read(reg_prod, 0, val, resp);
		check_val("start_busy prod", exp_p, val);
		end_test("start_busy", err_before);

		err_before = errors;
		axi_write(reg_op_a, 32'h1234_5678, 0, resp);
		axi_write(reg_op_b, 32'h9ABC_DEF0, 0, resp);
		axi_read(reg_op_a, 0, val, resp);
		check_val("readback op_a", 32'h1234_5678, val);
		axi_read(reg_op_b, 0, val, resp);
		check_val("readback op_b", 32'h9ABC_DEF0, val);
		axi_read(reg_ctrl, 0, val, resp);
		check_val("readback ctrl", 32'd0, val);
		end_test("readback", err_before);

		err_before = errors;
		axi_write(reg_op_a, 32'h4049_0FDB, 5, resp);
		check_val("backpressure write resp", 32'(resp_okay), 32'(resp));
		axi_read(reg_op_a, 6, val, resp);
		check_val("backpressure op_a", 32'h4049_0FDB, val);
		axi_read(reg_sum, 6, val, resp);
		check_val("backpressure sum", exp_s, val);
		end_test("backpressure", err_before);

		total = errors + dut.u_chk.err_count;
		$display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
			tests_run, tests_failed, errors, dut.u_chk.err_count);
		if (total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* src/float_add_pipelined.sv */
`timescale 1ns/1ps

module float_add_pipelined (
	input logic clk,
	input logic rst_n,
	input fpu_pkg::float_t float_in_a,
	input fpu_pkg::float_t float_in_b,
	input logic float_in_valid,
	output fpu_pkg::float_t float_out,
	output fpu_pkg::ovf_t float_ovf,
	output logic float_out_valid
);
	import fpu_pkg::*;

	logic a_sgn;
	logic b_sgn;
	exp_t a_exp;
	exp_t b_exp;
	frac_t a_frac;
	frac_t b_frac;
	logic signed [27:0] a_fix; // {2 sign bits, 1.23 mantissa, 2 guard bits}
	logic signed [27:0] b_fix;
	logic a_ge_b;
	logic [4:0] a_rsh;
	logic [4:0] b_rsh;
	logic [add_latency-1:0] vld_sr; // valid chain, one bit per stage
	exp_t exp_s1;
	logic signed [27:0] a_s1;
	logic signed [27:0] b_s1;

	logic signed [27:0] sum_c;
	logic [27:0] mag_c;
	logic [22:0] lsh_oh_c; // bit i means shift left by i+1
	logic sgn_s2;
	exp_t exp_s2;
	logic [26:0] mag_s2;
	logic zero_s2;
	logic small_s2; // magnitude below 1.0
	logic ovf_s2; // magnitude 2.0 or more
	logic [22:0] lsh_oh_s2;

	logic [4:0] lsh_n;
	logic signed [9:0] exp_incr;
	logic signed [9:0] exp_nml;
	logic [26:0] mag_nml;
	logic up_ovf;
	logic down_ovf;
	logic out_sgn;
	exp_t out_exp;
	frac_t out_frac;
	ovf_t out_ovf;

	// signed fixed point with the hidden one, two's complement for negative inputs
	function automatic logic signed [27:0] to_fixed(input logic sgn, input frac_t frac);
		logic signed [27:0] mag;
		mag = {3'b001, frac, 2'b00};
		return sgn ? -mag : mag;
	endfunction

	// alignment shift, anything past 31 is clamped
	function automatic logic [4:0] clamp_shift(input exp_t diff);
		return (|diff[7:5]) ? 5'd31 : diff[4:0];
	endfunction

	assign {a_sgn, a_exp, a_frac} = float_in_a;
	assign {b_sgn, b_exp, b_frac} = float_in_b;

	assign a_fix = to_fixed(a_sgn, a_frac);
	assign b_fix = to_fixed(b_sgn, b_frac);
	assign a_ge_b = a_exp >= b_exp;
	assign a_rsh = a_ge_b ? 5'd0 : clamp_shift(b_exp - a_exp);
	assign b_rsh = a_ge_b ? clamp_shift(a_exp - b_exp) : 5'd0;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[add_latency-2:0], float_in_valid};
	end

	// stage 1: align to the larger exponent
	always_ff @(posedge clk)
	begin
		if (float_in_valid)
		begin
			exp_s1 <= a_ge_b ? a_exp : b_exp;
			a_s1 <= a_fix >>> a_rsh; // truncating shift
			b_s1 <= b_fix >>> b_rsh;
		end
	end

	// stage 2: add, then work on sign and magnitude
	assign sum_c = a_s1 + b_s1; // range (-4, 4)
	assign mag_c = sum_c[27] ? -sum_c : sum_c;

	always_comb
	begin
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < 23; i++)
		begin
			lsh_oh_c[i] = mag_c[24-i] & !seen;
			seen = seen | mag_c[24-i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (vld_sr[0])
		begin
			sgn_s2 <= sum_c[27];
			exp_s2 <= exp_s1;
			mag_s2 <= mag_c[26:0];
			zero_s2 <= ~|mag_c[26:2]; // guard bits ignored
			small_s2 <= ~mag_c[26] & ~mag_c[25];
			ovf_s2 <= mag_c[26];
			lsh_oh_s2 <= lsh_oh_c;
		end
	end

	// stage 3: normalize
	always_comb
	begin
		lsh_n = 5'd0;
		for (int i = 0; i < 23; i++)
			if (lsh_oh_s2[i])
				lsh_n = 5'(i + 1);
	end

	assign exp_incr = ovf_s2 ? 10'sd1 : small_s2 ? -$signed({5'd0, lsh_n}) : 10'sd0;
	assign exp_nml = $signed({2'b00, exp_s2}) + exp_incr;

	// right normalize keeps the last fraction bit set
	assign mag_nml = ovf_s2 ? ((mag_s2 >> 1) | 27'd4) :
		small_s2 ? (mag_s2 << lsh_n) : mag_s2;

	assign down_ovf = exp_nml[9] | zero_s2;
	assign up_ovf = ~down_ovf & (exp_nml[8] | (&exp_nml[7:0])); // 255 and up saturates

	always_ff @(posedge clk)
	begin
		if (vld_sr[1])
		begin
			out_sgn <= sgn_s2 & ~down_ovf;
			out_exp <= down_ovf ? '0 : up_ovf ? '1 : exp_nml[7:0];
			out_frac <= down_ovf ? '0 : up_ovf ? '1 : mag_nml[24:2];
			out_ovf <= {up_ovf, down_ovf};
		end
	end

	assign float_out = {out_sgn, out_exp, out_frac};
	assign float_ovf = out_ovf;
	assign float_out_valid = vld_sr[add_latency-1];

endmodule

/* src/float_mul_pipelined.sv */
`timescale 1ns/1ps

module float_mul_pipelined (
	input logic clk,
	input logic rst_n,
	input fpu_pkg::float_t float_in_a,
	input fpu_pkg::float_t float_in_b,
	input logic float_in_valid,
	output fpu_pkg::float_t float_out,
	output fpu_pkg::ovf_t float_ovf,
	output logic float_out_valid
);
	import fpu_pkg::*;

	logic a_sgn;
	logic b_sgn;
	exp_t a_exp;
	exp_t b_exp;
	frac_t a_frac;
	frac_t b_frac;
	logic [mul_latency-1:0] vld_sr;

	logic sgn_s1;
	logic signed [9:0] exp_s1; // unbiased sum plus one bias, may go negative
	logic [47:0] prod_s1; // 2.46 fixed point, range [1, 4)

	logic norm_c;
	logic signed [9:0] exp_nml;
	frac_t frac_nml;
	logic up_ovf;
	logic down_ovf;
	logic out_sgn;
	exp_t out_exp;
	frac_t out_frac;
	ovf_t out_ovf;

	assign {a_sgn, a_exp, a_frac} = float_in_a;
	assign {b_sgn, b_exp, b_frac} = float_in_b;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[mul_latency-2:0], float_in_valid};
	end

	// stage 1: sign, exponent sum and full mantissa product
	always_ff @(posedge clk)
	begin
		if (float_in_valid)
		begin
			sgn_s1 <= a_sgn ^ b_sgn;
			exp_s1 <= 10'(a_exp) + 10'(b_exp) - 10'(exp_bias);
			prod_s1 <= {1'b1, a_frac} * {1'b1, b_frac};
		end
	end

	// stage 2: one place right when the product reached 2.0
	assign norm_c = prod_s1[47];
	assign exp_nml = exp_s1 + $signed({9'd0, norm_c});
	assign frac_nml = norm_c ? prod_s1[46:24] : prod_s1[45:23]; // truncated

	assign down_ovf = exp_nml[9];
	assign up_ovf = ~down_ovf & (exp_nml[8] | (&exp_nml[7:0]));

	always_ff @(posedge clk)
	begin
		if (vld_sr[0])
		begin
			out_sgn <= sgn_s1 & ~down_ovf;
			out_exp <= down_ovf ? '0 : up_ovf ? '1 : exp_nml[7:0];
			out_frac <= down_ovf ? '0 : up_ovf ? '1 : frac_nml;
			out_ovf <= {up_ovf, down_ovf};
		end
	end

	assign float_out = {out_sgn, out_exp, out_frac};
	assign float_ovf = out_ovf;
	assign float_out_valid = vld_sr[mul_latency-1];

endmodule

/* src/fpu_axil_regs.sv */
`timescale 1ns/1ps

module fpu_axil_regs (
	input logic clk,
	input logic rst_n,
	input fpu_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input fpu_pkg::axi_data_t wdata,
	input logic wvalid,
	output logic wready,
	output fpu_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input fpu_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output fpu_pkg::axi_data_t rdata,
	output fpu_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,
	input fpu_pkg::float_t sum,
	input fpu_pkg::float_t prod,
	input fpu_pkg::ovf_t add_ovf,
	input fpu_pkg::ovf_t mul_ovf,
	input logic busy,
	input logic done,
	output fpu_pkg::float_t op_a,
	output fpu_pkg::float_t op_b,
	output logic start
);
	import fpu_pkg::*;

	logic wr_rdy; // shared awready and wready
	logic wr_hs;
	axi_resp_t wr_resp_c;
	logic ar_hs;
	axi_data_t rd_data_c;
	axi_resp_t rd_resp_c;

	assign awready = wr_rdy;
	assign wready = wr_rdy;
	assign wr_hs = wr_rdy & awvalid & wvalid;

	// ready for one cycle once both channels are presented
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wr_rdy <= 1'b0;
		else
			wr_rdy <= !wr_rdy && awvalid && wvalid && !bvalid;
	end

	always_comb
	begin
		case (awaddr)
			reg_op_a, reg_op_b, reg_ctrl: wr_resp_c = resp_okay;
			default: wr_resp_c = resp_slverr; // read-only or unmapped
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (wr_hs && awaddr == reg_op_a)
			op_a <= wdata;
		if (wr_hs && awaddr == reg_op_b)
			op_b <= wdata;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bvalid <= 1'b0;
			bresp <= resp_okay;
			start <= 1'b0;
		end
		else
		begin
			if (wr_hs)
			begin
				bvalid <= 1'b1;
				bresp <= wr_resp_c;
			end
			else if (bready)
				bvalid <= 1'b0;
			start <= wr_hs && awaddr == reg_ctrl && wdata[0] && !busy; // dropped while busy
		end
	end

	// read side
	assign arready = !rvalid;
	assign ar_hs = arvalid & arready;

	always_comb
	begin
		rd_resp_c = resp_okay;
		case (araddr)
			reg_op_a: rd_data_c = op_a;
			reg_op_b: rd_data_c = op_b;
			reg_ctrl: rd_data_c = '0;
			reg_status: rd_data_c = {26'd0, mul_ovf, add_ovf, done, busy};
			reg_sum: rd_data_c = sum;
			reg_prod: rd_data_c = prod;
			default:
			begin
				rd_data_c = '0;
				rd_resp_c = resp_slverr;
			end
		endcase
	end

	// data only loads with a new address, so it holds under back-pressure
	always_ff @(posedge clk)
	begin
		if (ar_hs)
		begin
			rdata <= rd_data_c;
			rresp <= rd_resp_c;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rvalid <= 1'b0;
		else if (ar_hs)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

endmodule

/* src/fpu_axil_top.sv */
`timescale 1ns/1ps

module fpu_axil_top (
	input logic clk,
	input logic rst_n,
	input fpu_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input fpu_pkg::axi_data_t wdata,
	input logic [3:0] wstrb, // full-word writes only
	input logic wvalid,
	output logic wready,
	output fpu_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input fpu_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output fpu_pkg::axi_data_t rdata,
	output fpu_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready
);
	import fpu_pkg::*;

	float_t op_a;
	float_t op_b;
	logic start;
	float_t add_out;
	float_t mul_out;
	ovf_t add_flags;
	ovf_t mul_flags;
	logic add_vld;
	logic mul_vld;
	float_t sum;
	float_t prod;
	ovf_t add_ovf;
	ovf_t mul_ovf;
	logic busy;
	logic done;

	fpu_axil_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.sum(sum), .prod(prod), .add_ovf(add_ovf), .mul_ovf(mul_ovf),
		.busy(busy), .done(done),
		.op_a(op_a), .op_b(op_b), .start(start)
	);

	// both pipelines take the same operand pair
	float_add_pipelined u_add (
		.clk(clk), .rst_n(rst_n),
		.float_in_a(op_a), .float_in_b(op_b), .float_in_valid(start),
		.float_out(add_out), .float_ovf(add_flags), .float_out_valid(add_vld)
	);

	float_mul_pipelined u_mul (
		.clk(clk), .rst_n(rst_n),
		.float_in_a(op_a), .float_in_b(op_b), .float_in_valid(start),
		.float_out(mul_out), .float_ovf(mul_flags), .float_out_valid(mul_vld)
	);

	fpu_result_collect u_collect (
		.clk(clk), .rst_n(rst_n), .start(start),
		.add_result(add_out), .mul_result(mul_out),
		.add_flags(add_flags), .mul_flags(mul_flags),
		.add_valid(add_vld), .mul_valid(mul_vld),
		.sum(sum), .prod(prod), .add_ovf(add_ovf), .mul_ovf(mul_ovf),
		.busy(busy), .done(done)
	);

endmodule

/* src/fpu_pkg.sv */
package fpu_pkg;

	// single-precision fields
	typedef logic [31:0] float_t; // {sign, exponent, fraction}
	typedef logic [7:0] exp_t; // biased exponent
	typedef logic [22:0] frac_t; // stored fraction, hidden one not included
	typedef logic [1:0] ovf_t; // {overflow, underflow}

	// AXI4-Lite
	typedef logic [5:0] axi_addr_t; // byte address
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t resp_okay = 2'b00;
	localparam axi_resp_t resp_slverr = 2'b10;

	// register map
	localparam axi_addr_t reg_op_a = 6'h00; // rw
	localparam axi_addr_t reg_op_b = 6'h04; // rw
	localparam axi_addr_t reg_ctrl = 6'h08; // bit 0 starts, reads zero
	localparam axi_addr_t reg_status = 6'h0C; // {mul flags, add flags, done, busy}
	localparam axi_addr_t reg_sum = 6'h10; // ro
	localparam axi_addr_t reg_prod = 6'h14; // ro

	// pipeline depths in cycles from in_valid to out_valid
	localparam int add_latency = 3;
	localparam int mul_latency = 2;

	localparam int exp_bias = 127;

endpackage

/* src/fpu_result_collect.sv */
`timescale 1ns/1ps

module fpu_result_collect (
	input logic clk,
	input logic rst_n,
	input logic start,
	input fpu_pkg::float_t add_result,
	input fpu_pkg::float_t mul_result,
	input fpu_pkg::ovf_t add_flags,
	input fpu_pkg::ovf_t mul_flags,
	input logic add_valid,
	input logic mul_valid,
	output fpu_pkg::float_t sum,
	output fpu_pkg::float_t prod,
	output fpu_pkg::ovf_t add_ovf,
	output fpu_pkg::ovf_t mul_ovf,
	output logic busy,
	output logic done
);
	import fpu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_done
	} state_t;

	state_t state;
	state_t state_nxt;
	logic got_add; // adder result already captured
	logic got_mul;
	logic in_wait;

	assign in_wait = state == st_wait;

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_idle: if (start) state_nxt = st_wait;
			st_wait: if ((got_add | add_valid) & (got_mul | mul_valid)) state_nxt = st_done;
			st_done: if (start) state_nxt = st_wait; // done clears here
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			got_add <= 1'b0;
			got_mul <= 1'b0;
			add_ovf <= '0;
			mul_ovf <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (start && !in_wait)
			begin
				got_add <= 1'b0;
				got_mul <= 1'b0;
			end
			else if (in_wait)
			begin
				got_add <= got_add | add_valid;
				got_mul <= got_mul | mul_valid;
			end
			if (in_wait && add_valid)
				add_ovf <= add_flags;
			if (in_wait && mul_valid)
				mul_ovf <= mul_flags;
		end
	end

	// results held until the next operation lands
	always_ff @(posedge clk)
	begin
		if (in_wait && add_valid)
			sum <= add_result;
		if (in_wait && mul_valid)
			prod <= mul_result;
	end

	assign busy = in_wait;
	assign done = state == st_done;

endmodule

/* verilog.f */
src/fpu_pkg.sv
src/float_add_pipelined.sv
src/float_mul_pipelined.sv
src/fpu_result_collect.sv
src/fpu_axil_regs.sv
src/fpu_axil_top.sv
sim/fpu_axil_chk.sv
sim/fpu_axil_tb.sv
